/* rtl/fb_fill_pkg.sv */
`default_nettype none

package fb_fill_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int PIX_W  = 32;
    localparam int MASK_W = DATA_W / 8;

    localparam logic [ADDR_W-1:0] FB_BASE = 32'hF000_0000;

    // default 800x600 frame, six bands
    localparam int DEF_H_ACTIVE      = 800;
    localparam int DEF_V_ACTIVE      = 600;
    localparam int DEF_BAND_ROWS     = 100;
    localparam int DEF_REFILL_CYCLES = 100_000_000;

    localparam logic [23:0] COLOR_INIT = 24'hFF0000;

    // commands the arbiter can have in flight
    localparam int OUTS_DEPTH = 4;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              read;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] wmask;
    } mem_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    typedef enum logic {
        SRC_FILL,
        SRC_SCAN
    } src_e;

    typedef enum logic {
        FILL_RUN,
        FILL_WAIT
    } fill_state_e;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DRAIN
    } scan_state_e;

endpackage

`default_nettype wire

/* rtl/frame_filler.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_filler #(
    parameter int H_ACTIVE      = fb_fill_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE      = fb_fill_pkg::DEF_V_ACTIVE,
    parameter int BAND_ROWS     = fb_fill_pkg::DEF_BAND_ROWS,
    parameter int REFILL_CYCLES = fb_fill_pkg::DEF_REFILL_CYCLES
) (
    input  wire logic             ui_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_calib_ok,
    output logic                  o_cmd_valid,
    output fb_fill_pkg::mem_cmd_t o_cmd,
    input  wire logic             i_cmd_ready
);
    import fb_fill_pkg::*;

    localparam int PIX_NUM = H_ACTIVE * V_ACTIVE;
    localparam int CNT_W   = $clog2(PIX_NUM + 1);
    localparam int COL_W   = $clog2(H_ACTIVE + 1);
    localparam int ROW_W   = $clog2(BAND_ROWS + 1);
    localparam int REF_W   = $clog2(REFILL_CYCLES + 1);

    fill_state_e      state_q;
    logic [CNT_W-1:0] pix_cnt;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic [REF_W-1:0] refill_cnt;
    logic [23:0]      color_q;
    logic             xfer;
    logic             last_col;
    logic             last_row;
    logic             last_pix;
    logic             refill_wrap;

    assign xfer        = o_cmd_valid && i_cmd_ready;
    assign last_col    = col_cnt == COL_W'(H_ACTIVE - 1);
    assign last_row    = row_cnt == ROW_W'(BAND_ROWS - 1);
    assign last_pix    = pix_cnt == CNT_W'(PIX_NUM - 1);
    assign refill_wrap = refill_cnt == REF_W'(REFILL_CYCLES - 1);

    // refill period, runs as soon as memory is up
    always_ff @(posedge ui_clk) begin
        if (!i_rst_n || !i_calib_ok) begin
            refill_cnt <= '0;
        end else if (refill_wrap) begin
            refill_cnt <= '0;
        end else begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!i_rst_n || !i_calib_ok) begin
            state_q <= FILL_RUN;
            pix_cnt <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            case (state_q)
                FILL_RUN: begin
                    if (xfer) begin
                        pix_cnt <= pix_cnt + 1'b1;
                        col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                        if (last_col) begin
                            row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                        end
                        if (last_pix) begin
                            state_q <= FILL_WAIT;
                        end
                    end
                end
                FILL_WAIT: begin
                    // repaint from pixel 0 on the next wrap
                    if (refill_wrap) begin
                        state_q <= FILL_RUN;
                        pix_cnt <= '0;
                        col_cnt <= '0;
                        row_cnt <= '0;
                    end
                end
                default: state_q <= FILL_RUN;
            endcase
        end
    end

    // rotate one byte right at each band end
    always_ff @(posedge ui_clk) begin
        if (!i_rst_n) begin
            color_q <= COLOR_INIT;
        end else if (xfer && last_col && last_row) begin
            color_q <= {color_q[7:0], color_q[23:8]};
        end
    end

    assign o_cmd_valid = i_calib_ok && (state_q == FILL_RUN) && (pix_cnt < CNT_W'(PIX_NUM));
    assign o_cmd.addr  = FB_BASE + ADDR_W'({pix_cnt, 2'b00});
    assign o_cmd.read  = 1'b0;
    assign o_cmd.wdata = {2{PIX_W'(color_q)}};
    // odd pixel sits in the upper lane
    assign o_cmd.wmask = o_cmd.addr[2] ? 8'hF0 : 8'h0F;

    a_cmd_stable: assert property (@(posedge ui_clk) disable iff (!i_rst_n)
        o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd));

endmodule

`default_nettype wire

/* rtl/scanout_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module scanout_reader #(
    parameter int H_ACTIVE = fb_fill_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = fb_fill_pkg::DEF_V_ACTIVE
) (
    input  wire logic                  ui_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_calib_ok,
    input  wire logic                  i_scan_start,
    output logic                       o_cmd_valid,
    output fb_fill_pkg::mem_cmd_t      o_cmd,
    input  wire logic                  i_cmd_ready,
    input  wire logic                  i_rsp_valid,
    input  wire fb_fill_pkg::mem_rsp_t i_rsp,
    output logic                       o_pix_valid,
    output logic [23:0]                o_pix,
    output logic                       o_scan_done,
    output logic                       o_rd_err
);
    import fb_fill_pkg::*;

    localparam int PIX_NUM = H_ACTIVE * V_ACTIVE;
    localparam int CNT_W   = $clog2(PIX_NUM + 1);
    localparam int IF_W    = $clog2(OUTS_DEPTH + 1);

    scan_state_e      state_q;
    logic [CNT_W-1:0] issue_cnt;
    logic [CNT_W-1:0] rsp_cnt;
    logic [IF_W-1:0]  inflight;
    logic             xfer;

    assign xfer = o_cmd_valid && i_cmd_ready;

    always_ff @(posedge ui_clk) begin
        if (!i_rst_n || !i_calib_ok) begin
            state_q   <= SCAN_IDLE;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            inflight  <= '0;
        end else begin
            inflight <= inflight + IF_W'(xfer) - IF_W'(i_rsp_valid);
            if (xfer) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (i_rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            case (state_q)
                SCAN_IDLE: begin
                    if (i_scan_start) begin
                        state_q   <= SCAN_RUN;
                        issue_cnt <= '0;
                        rsp_cnt   <= '0;
                    end
                end
                SCAN_RUN: begin
                    if (xfer && issue_cnt == CNT_W'(PIX_NUM - 1)) begin
                        state_q <= SCAN_DRAIN;
                    end
                end
                SCAN_DRAIN: begin
                    if (o_scan_done) begin
                        state_q <= SCAN_IDLE;
                    end
                end
                default: state_q <= SCAN_IDLE;
            endcase
        end
    end

    // sticky until reset
    always_ff @(posedge ui_clk) begin
        if (!i_rst_n) begin
            o_rd_err <= 1'b0;
        end else if (i_rsp_valid && i_rsp.err) begin
            o_rd_err <= 1'b1;
        end
    end

    assign o_cmd_valid = (state_q == SCAN_RUN) && (inflight < IF_W'(OUTS_DEPTH));
    assign o_cmd.addr  = FB_BASE + ADDR_W'({issue_cnt, 2'b00});
    assign o_cmd.read  = 1'b1;
    assign o_cmd.wdata = '0;
    assign o_cmd.wmask = '0;

    // lane follows pixel parity
    assign o_pix_valid = i_rsp_valid;
    assign o_pix       = rsp_cnt[0] ? i_rsp.rdata[PIX_W +: 24] : i_rsp.rdata[23:0];
    assign o_scan_done = i_rsp_valid && (rsp_cnt == CNT_W'(PIX_NUM - 1));

    a_inflight_max: assert property (@(posedge ui_clk) disable iff (!i_rst_n)
        inflight <= IF_W'(OUTS_DEPTH));

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic                  ui_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_fill_valid,
    input  wire fb_fill_pkg::mem_cmd_t i_fill_cmd,
    output logic                       o_fill_ready,
    input  wire logic                  i_scan_valid,
    input  wire fb_fill_pkg::mem_cmd_t i_scan_cmd,
    output logic                       o_scan_ready,
    output logic                       o_scan_rsp_valid,
    output logic                       o_mem_cmd_valid,
    output fb_fill_pkg::mem_cmd_t      o_mem_cmd,
    input  wire logic                  i_mem_cmd_ready,
    input  wire logic                  i_mem_rsp_valid
);
    import fb_fill_pkg::*;

    localparam int PTR_W = (OUTS_DEPTH > 1) ? $clog2(OUTS_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUTS_DEPTH + 1);

    src_e             grant;
    src_e             rr_next_q;
    src_e             hold_src_q;
    logic             hold_q;
    logic             sel_valid;
    logic             q_full;
    logic             push;
    logic             pop;
    src_e             src_q [OUTS_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_cnt;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(OUTS_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // held grant first, then round robin on contention
    always_comb begin
        if (hold_q) begin
            grant = hold_src_q;
        end else if (i_fill_valid && i_scan_valid) begin
            grant = rr_next_q;
        end else if (i_scan_valid) begin
            grant = SRC_SCAN;
        end else begin
            grant = SRC_FILL;
        end
    end

    assign sel_valid       = (grant == SRC_SCAN) ? i_scan_valid : i_fill_valid;
    assign q_full          = q_cnt == CNT_W'(OUTS_DEPTH);
    assign o_mem_cmd_valid = sel_valid && !q_full;
    assign o_mem_cmd       = (grant == SRC_SCAN) ? i_scan_cmd : i_fill_cmd;
    assign o_fill_ready    = (grant == SRC_FILL) && i_mem_cmd_ready && !q_full;
    assign o_scan_ready    = (grant == SRC_SCAN) && i_mem_cmd_ready && !q_full;

    assign push = o_mem_cmd_valid && i_mem_cmd_ready;
    assign pop  = i_mem_rsp_valid;

    // filler responses are dropped here
    assign o_scan_rsp_valid = pop && (src_q[rd_ptr] == SRC_SCAN);

    always_ff @(posedge ui_clk) begin
        if (push) begin
            src_q[wr_ptr] <= grant;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!i_rst_n) begin
            hold_q     <= 1'b0;
            hold_src_q <= SRC_FILL;
            rr_next_q  <= SRC_FILL;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
        end else begin
            hold_q     <= sel_valid && !push;
            hold_src_q <= grant;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
                if (grant == SRC_FILL) begin
                    rr_next_q <= SRC_SCAN;
                end else begin
                    rr_next_q <= SRC_FILL;
                end
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            q_cnt <= q_cnt + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_rsp_not_empty: assert property (@(posedge ui_clk) disable iff (!i_rst_n)
        i_mem_rsp_valid |-> q_cnt != '0);

    a_push_not_full: assert property (@(posedge ui_clk) disable iff (!i_rst_n)
        o_mem_cmd_valid && i_mem_cmd_ready |-> q_cnt < CNT_W'(OUTS_DEPTH));

endmodule

`default_nettype wire

/* rtl/fb_fill_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_fill_top #(
    parameter int H_ACTIVE      = fb_fill_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE      = fb_fill_pkg::DEF_V_ACTIVE,
    parameter int BAND_ROWS     = fb_fill_pkg::DEF_BAND_ROWS,
    parameter int REFILL_CYCLES = fb_fill_pkg::DEF_REFILL_CYCLES
) (
    input  wire logic                  ui_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_calib_done,
    input  wire logic                  i_scan_start,
    output logic                       o_mem_cmd_valid,
    output fb_fill_pkg::mem_cmd_t      o_mem_cmd,
    input  wire logic                  i_mem_cmd_ready,
    input  wire logic                  i_mem_rsp_valid,
    input  wire fb_fill_pkg::mem_rsp_t i_mem_rsp,
    output logic                       o_pix_valid,
    output logic [23:0]                o_pix,
    output logic                       o_scan_done,
    output logic                       o_rd_err
);
    import fb_fill_pkg::*;

    logic     calib_q1;
    logic     calib_ok;
    logic     fill_valid;
    mem_cmd_t fill_cmd;
    logic     fill_ready;
    logic     scan_valid;
    mem_cmd_t scan_cmd;
    logic     scan_ready;
    logic     scan_rsp_valid;

    // calib done comes from the memory side
    always_ff @(posedge ui_clk) begin
        if (!i_rst_n) begin
            calib_q1 <= 1'b0;
            calib_ok <= 1'b0;
        end else begin
            calib_q1 <= i_calib_done;
            calib_ok <= calib_q1;
        end
    end

    frame_filler #(
        .H_ACTIVE      (H_ACTIVE),
        .V_ACTIVE      (V_ACTIVE),
        .BAND_ROWS     (BAND_ROWS),
        .REFILL_CYCLES (REFILL_CYCLES)
    ) u_filler (
        .ui_clk      (ui_clk),
        .i_rst_n     (i_rst_n),
        .i_calib_ok  (calib_ok),
        .o_cmd_valid (fill_valid),
        .o_cmd       (fill_cmd),
        .i_cmd_ready (fill_ready)
    );

    scanout_reader #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_reader (
        .ui_clk       (ui_clk),
        .i_rst_n      (i_rst_n),
        .i_calib_ok   (calib_ok),
        .i_scan_start (i_scan_start),
        .o_cmd_valid  (scan_valid),
        .o_cmd        (scan_cmd),
        .i_cmd_ready  (scan_ready),
        .i_rsp_valid  (scan_rsp_valid),
        .i_rsp        (i_mem_rsp),
        .o_pix_valid  (o_pix_valid),
        .o_pix        (o_pix),
        .o_scan_done  (o_scan_done),
        .o_rd_err     (o_rd_err)
    );

    mem_arbiter u_arbiter (
        .ui_clk           (ui_clk),
        .i_rst_n          (i_rst_n),
        .i_fill_valid     (fill_valid),
        .i_fill_cmd       (fill_cmd),
        .o_fill_ready     (fill_ready),
        .i_scan_valid     (scan_valid),
        .i_scan_cmd       (scan_cmd),
        .o_scan_ready     (scan_ready),
        .o_scan_rsp_valid (scan_rsp_valid),
        .o_mem_cmd_valid  (o_mem_cmd_valid),
        .o_mem_cmd        (o_mem_cmd),
        .i_mem_cmd_ready  (i_mem_cmd_ready),
        .i_mem_rsp_valid  (i_mem_rsp_valid)
    );

endmodule

`default_nettype wire

/* dv/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] ERR_ADDR = 32'hF000_0054
) (
    input  wire logic                  ui_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_cmd_valid,
    input  wire fb_fill_pkg::mem_cmd_t i_cmd,
    output logic                       o_cmd_ready,
    output logic                       o_rsp_valid,
    output fb_fill_pkg::mem_rsp_t      o_rsp
);
    import fb_fill_pkg::*;

    logic [DATA_W-1:0] mem [64];
    mem_cmd_t          wr_log [$];
    mem_cmd_t          rd_log [$];
    logic              stage_valid = 1'b0;
    mem_rsp_t          stage_rsp;
    mem_rsp_t          next_rsp;
    logic [5:0]        idx;
    logic              xfer;

    assign xfer          = i_cmd_valid && o_cmd_ready;
    assign idx           = i_cmd.addr[8:3];
    assign next_rsp.rdata = i_cmd.read ? mem[idx] : '0;
    assign next_rsp.err   = i_cmd.read && (i_cmd.addr == ERR_ADDR);

    // fill word holds its own address and the inverse
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = {FB_BASE + 32'(i * 8), ~(FB_BASE + 32'(i * 8))};
        end
    end

    // ready drops about one cycle in four
    initial begin
        o_cmd_ready = 1'b0;
        o_rsp_valid = 1'b0;
        o_rsp       = '0;
        void'($urandom(29));
        forever begin
            @(posedge ui_clk);
            o_cmd_ready <= ($urandom % 4) != 0;
        end
    end

    // response leaves two cycles after the transfer
    always @(posedge ui_clk) begin
        if (!i_rst_n) begin
            stage_valid <= 1'b0;
            o_rsp_valid <= 1'b0;
        end else begin
            stage_valid <= xfer;
            stage_rsp   <= next_rsp;
            o_rsp_valid <= stage_valid;
            o_rsp       <= stage_rsp;
            if (xfer && i_cmd.read) begin
                rd_log.push_back(i_cmd);
            end else if (xfer) begin
                wr_log.push_back(i_cmd);
                for (int b = 0; b < MASK_W; b++) begin
                    if (i_cmd.wmask[b]) begin
                        mem[idx][8*b +: 8] <= i_cmd.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_fb_fill.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fb_fill;
    import fb_fill_pkg::*;

    localparam int H_ACT   = 8;
    localparam int V_ACT   = 6;
    localparam int BAND    = 1;
    localparam int REFILL  = 400;
    localparam int PIX_NUM = H_ACT * V_ACT;
    localparam int TIMEOUT = 3 * REFILL + 2000;

    logic        ui_clk = 1'b0;
    logic        i_rst_n;
    logic        i_calib_done;
    logic        i_scan_start;
    logic        o_mem_cmd_valid;
    mem_cmd_t    o_mem_cmd;
    logic        i_mem_cmd_ready;
    logic        i_mem_rsp_valid;
    mem_rsp_t    i_mem_rsp;
    logic        o_pix_valid;
    logic [23:0] o_pix;
    logic        o_scan_done;
    logic        o_rd_err;
    int          cycle_cnt = 0;
    logic        err_seen = 1'b0;
    logic [23:0] pix_q [$];
    bit          done_q [$];

    fb_fill_top #(
        .H_ACTIVE      (H_ACT),
        .V_ACTIVE      (V_ACT),
        .BAND_ROWS     (BAND),
        .REFILL_CYCLES (REFILL)
    ) UUT (
        .ui_clk          (ui_clk),
        .i_rst_n         (i_rst_n),
        .i_calib_done    (i_calib_done),
        .i_scan_start    (i_scan_start),
        .o_mem_cmd_valid (o_mem_cmd_valid),
        .o_mem_cmd       (o_mem_cmd),
        .i_mem_cmd_ready (i_mem_cmd_ready),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp       (i_mem_rsp),
        .o_pix_valid     (o_pix_valid),
        .o_pix           (o_pix),
        .o_scan_done     (o_scan_done),
        .o_rd_err        (o_rd_err)
    );

    tb_mem_model u_mem (
        .ui_clk      (ui_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (o_mem_cmd_valid),
        .i_cmd       (o_mem_cmd),
        .o_cmd_ready (i_mem_cmd_ready),
        .o_rsp_valid (i_mem_rsp_valid),
        .o_rsp       (i_mem_rsp)
    );

    always #50 ui_clk = ~ui_clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_cmd(string name, mem_cmd_t got, mem_cmd_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_pix(string name, logic [23:0] got, logic [23:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, bit got, bit exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got %h expected %h", name, got, exp));
        end
    endtask

    // color rotates one byte right per band
    function automatic mem_cmd_t exp_write(int p);
        mem_cmd_t    c;
        logic [23:0] color;
        color = COLOR_INIT;
        for (int k = 0; k < p / (H_ACT * BAND); k++) begin
            color = {color[7:0], color[23:8]};
        end
        c.addr  = FB_BASE + 32'(4 * p);
        c.read  = 1'b0;
        c.wdata = {8'h00, color, 8'h00, color};
        c.wmask = c.addr[2] ? 8'hF0 : 8'h0F;
        return c;
    endfunction

    function automatic mem_cmd_t exp_read(int p);
        mem_cmd_t c;
        c       = '0;
        c.addr  = FB_BASE + 32'(4 * p);
        c.read  = 1'b1;
        return c;
    endfunction

    function automatic logic [23:0] stored_color(int p);
        logic [DATA_W-1:0] word;
        word = u_mem.mem[p / 2];
        return (p % 2) ? word[55:32] : word[23:0];
    endfunction

    task automatic wait_writes(int n);
        while (u_mem.wr_log.size() < n) begin
            @(posedge ui_clk);
        end
    endtask

    task automatic check_frame(int first);
        for (int p = 0; p < PIX_NUM; p++) begin
            check_cmd($sformatf("o_mem_cmd write %0d", first + p),
                      u_mem.wr_log[first + p], exp_write(p));
        end
    endtask

    task automatic run_scan();
        int rd_base;
        rd_base = u_mem.rd_log.size();
        pix_q.delete();
        done_q.delete();
        @(posedge ui_clk);
        i_scan_start <= 1'b1;
        @(posedge ui_clk);
        i_scan_start <= 1'b0;
        while (pix_q.size() < PIX_NUM) begin
            @(posedge ui_clk);
        end
        repeat (8) @(posedge ui_clk);
        if (pix_q.size() != PIX_NUM || u_mem.rd_log.size() != rd_base + PIX_NUM) begin
            abort_run($sformatf("scan gave %0d pixels from %0d reads, expected %0d",
                                pix_q.size(), u_mem.rd_log.size() - rd_base, PIX_NUM));
        end
        for (int p = 0; p < PIX_NUM; p++) begin
            check_cmd($sformatf("o_mem_cmd read %0d", p), u_mem.rd_log[rd_base + p],
                      exp_read(p));
            check_pix($sformatf("o_pix %0d", p), pix_q[p], stored_color(p));
            check_flag($sformatf("o_scan_done at pixel %0d", p), done_q[p], p == PIX_NUM - 1);
        end
    endtask

    task automatic test_calib_hold();
        for (int i = 0; i < 50; i++) begin
            @(posedge ui_clk);
            check_flag("o_mem_cmd_valid", o_mem_cmd_valid, 1'b0);
            // start pulse must be ignored before calibration
            i_scan_start <= (i == 20);
        end
    endtask

    task automatic test_first_fill();
        i_calib_done <= 1'b1;
        wait_writes(PIX_NUM);
        check_frame(0);
        if (u_mem.rd_log.size() != 0) begin
            abort_run("reads were issued although no scan was accepted");
        end
    endtask

    task automatic test_scan_idle();
        check_flag("o_rd_err", o_rd_err, 1'b0);
        run_scan();
        check_flag("o_rd_err", o_rd_err, 1'b1);
        if (u_mem.wr_log.size() != PIX_NUM) begin
            abort_run("filler wrote again before the refill period ended");
        end
    endtask

    task automatic test_scan_during_refill();
        int wr_before;
        wait_writes(PIX_NUM + 1);
        wr_before = u_mem.wr_log.size();
        run_scan();
        if (u_mem.wr_log.size() <= wr_before) begin
            abort_run("filler made no progress while the scan was running");
        end
    endtask

    task automatic test_refill_frame();
        wait_writes(2 * PIX_NUM);
        check_frame(PIX_NUM);
        repeat (10) @(posedge ui_clk);
        check_flag("o_rd_err", o_rd_err, 1'b1);
    endtask

    // pixel capture and sticky error watch
    always @(posedge ui_clk) begin
        if (o_pix_valid) begin
            pix_q.push_back(o_pix);
            done_q.push_back(o_scan_done);
        end else begin
            check_flag("o_scan_done", o_scan_done, 1'b0);
        end
        if (o_rd_err) begin
            err_seen <= 1'b1;
        end
        if (err_seen) begin
            check_flag("o_rd_err", o_rd_err, 1'b1);
        end
    end

    always @(posedge ui_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        i_rst_n      = 1'b0;
        i_calib_done = 1'b0;
        i_scan_start = 1'b0;
        repeat (10) @(posedge ui_clk);
        check_flag("o_mem_cmd_valid", o_mem_cmd_valid, 1'b0);
        check_flag("o_pix_valid", o_pix_valid, 1'b0);
        check_flag("o_scan_done", o_scan_done, 1'b0);
        check_flag("o_rd_err", o_rd_err, 1'b0);
        i_rst_n <= 1'b1;
        test_calib_hold();
        test_first_fill();
        test_scan_idle();
        test_scan_during_refill();
        test_refill_frame();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* fb_fill.f */
rtl/fb_fill_pkg.sv
rtl/frame_filler.sv
rtl/scanout_reader.sv
rtl/mem_arbiter.sv
rtl/fb_fill_top.sv
dv/tb_mem_model.sv
dv/tb_fb_fill.sv
